// ==== source/memtest_pkg.sv ====
/*
 * Shared types and constants of the DDR3 self-test controller.
 * Every design file takes what it needs through a wildcard import.
 */
package memtest_pkg;

	// ----------------------------------------
	// Widths
	// ----------------------------------------
	// Word address in 16-bit units: [26:24] bank, [23:10] row, [9:0] column
	typedef logic [26:0]  dram_addr_t;
	typedef logic [127:0] dram_data_t;
	typedef logic [7:0]   char_t;
	typedef logic [6:0]   rom_ptr_t;
	typedef logic [5:0]   led_t;

	// ----------------------------------------
	// Test range and print format
	// ----------------------------------------
	localparam dram_addr_t addr_step = 27'd8;
	localparam int test_word_count = 64;
	// Progress line every this many bursts
	localparam int progress_words = 16;
	localparam int addr_hex_digits = 7;
	localparam int data_hex_digits = 32;

	typedef logic [$clog2(test_word_count)-1:0] burst_t;
	// Address widened to whole hex digits
	typedef logic [4*addr_hex_digits-1:0] hex_addr_t;

	// Phase codes on the LEDs
	localparam led_t led_idle      = 6'b101010;
	localparam led_t led_wait_init = 6'b000011;
	localparam led_t led_write     = 6'b001100;
	localparam led_t led_read      = 6'b111110;
	localparam led_t led_done      = 6'b001111;

	// Special bytes in the message ROM
	localparam char_t char_end = 8'h00;
	localparam char_t char_cr  = 8'h0D;
	localparam char_t char_lf  = 8'h0A;
	localparam char_t tok_addr = "@";
	localparam char_t tok_data = "#";

	// Value of each message is its start offset in the ROM
	typedef enum rom_ptr_t {
		msg_title      = 7'd0,
		msg_init_ok    = 7'd23,
		msg_write      = 7'd40,
		msg_read_error = 7'd46,
		msg_read       = 7'd62
	} msg_id_t;

	typedef struct packed {
		msg_id_t    msg;
		hex_addr_t  addr;
		dram_data_t data;
	} print_req_t;

	typedef struct packed {
		dram_addr_t addr;
		logic       write;
		dram_data_t wdata;
	} dram_req_t;

	typedef enum logic [3:0] {
		seq_wait_button, seq_title_wait, seq_wait_init, seq_init_ok_wait,
		seq_burst, seq_progress_wait, seq_request, seq_read_data,
		seq_error_wait, seq_done
	} seq_state_t;

	typedef enum logic [1:0] {
		pr_idle, pr_fetch, pr_send
	} print_state_t;

	// Upper case ASCII hex digit
	function automatic char_t hex_digit(input logic [3:0] nibble);
		if (nibble < 4'd10) begin
			return 8'h30 + {4'd0, nibble};
		end
		return 8'h37 + {4'd0, nibble};
	endfunction

endpackage

// ==== source/message_rom.sv ====
/*
 * Constant text table of the self-test messages.
 * Read combinationally by the print engine; the offset of each message
 * is its msg_id_t value, and a zero byte closes it.
 */
`timescale 1ns/1ps

module message_rom
	import memtest_pkg::*;
(
	input  rom_ptr_t rom_ptr,
	output char_t    rom_char
);

	localparam int text_len = 68;

	// ----------------------------------------
	// Byte image
	// ----------------------------------------
	// @ stands for the address, # for the data
	localparam char_t [0:text_len-1] msg_text = {
		// Title, offset 0
		"DDR3 Test", char_cr, char_lf,
		"Wait init", char_cr, char_lf,
		char_end,
		// Init done, offset 23
		"Init OK", char_cr, char_lf,
		"Write", char_cr, char_lf,
		char_end,
		// Write progress, offset 40
		"W:", tok_addr, char_cr, char_lf,
		char_end,
		// Mismatch report, offset 46
		" Read Err ", tok_addr, ":", tok_data, char_cr, char_lf,
		char_end,
		// Read progress, offset 62
		"R:", tok_addr, char_cr, char_lf,
		char_end
	};

	// Past the last message reads as end of text
	assign rom_char = (rom_ptr < rom_ptr_t'(text_len)) ? msg_text[rom_ptr] : char_end;

endmodule

// ==== source/message_printer.sv ====
/*
 * Print engine. Walks one message of the ROM per request and sends
 * its bytes on a valid/ready character stream; @ and # become the
 * latched address and data in hex. Done pulses once at the end.
 */
`timescale 1ns/1ps

module message_printer
	import memtest_pkg::*;
(
	input  logic       clk,
	input  logic       reset_n,
	input  logic       print_start,
	input  print_req_t print_req,
	output rom_ptr_t   rom_ptr,
	input  char_t      rom_char,
	output logic       busy,
	output logic       print_done,
	output logic       char_valid,
	input  logic       char_ready,
	output char_t      char_data
);

	localparam int count_bits = $clog2(data_hex_digits);
	localparam int data_bits = $bits(dram_data_t);

	print_state_t          state;
	print_req_t            req_q;
	rom_ptr_t              ptr_q;
	// Value being printed, next digit at the top
	dram_data_t            shift_q;
	logic [count_bits-1:0] digits_left;
	char_t                 char_q;
	logic                  valid_q;
	logic                  done_q;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state   <= pr_idle;
			valid_q <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				// ----------------------------------------
				// Wait for a request
				// ----------------------------------------
				pr_idle: begin
					if (print_start) begin
						req_q <= print_req;
						ptr_q <= print_req.msg;
						state <= pr_fetch;
					end
				end
				// ----------------------------------------
				// Classify the byte under the pointer
				// ----------------------------------------
				pr_fetch: begin
					case (rom_char)
						char_end: begin
							// Busy drops with the done pulse
							done_q <= 1'b1;
							state  <= pr_idle;
						end
						tok_addr: begin
							shift_q     <= {req_q.addr, {(data_bits - $bits(hex_addr_t)){1'b0}}};
							digits_left <= count_bits'(addr_hex_digits - 1);
							char_q      <= hex_digit(req_q.addr[$bits(hex_addr_t)-1 -: 4]);
							valid_q     <= 1'b1;
							ptr_q       <= ptr_q + 7'd1;
							state       <= pr_send;
						end
						tok_data: begin
							shift_q     <= req_q.data;
							digits_left <= count_bits'(data_hex_digits - 1);
							char_q      <= hex_digit(req_q.data[data_bits-1 -: 4]);
							valid_q     <= 1'b1;
							ptr_q       <= ptr_q + 7'd1;
							state       <= pr_send;
						end
						default: begin
							// Plain text, a single character
							digits_left <= '0;
							char_q      <= rom_char;
							valid_q     <= 1'b1;
							ptr_q       <= ptr_q + 7'd1;
							state       <= pr_send;
						end
					endcase
				end
				// ----------------------------------------
				// Hold the character until accepted
				// ----------------------------------------
				pr_send: begin
					if (char_ready) begin
						if (digits_left == '0) begin
							valid_q <= 1'b0;
							state   <= pr_fetch;
						end else begin
							// Next hex digit, back to back
							shift_q     <= shift_q << 4;
							digits_left <= digits_left - 1'b1;
							char_q      <= hex_digit(shift_q[data_bits-5 -: 4]);
						end
					end
				end
				default: state <= pr_idle;
			endcase
		end
	end

	assign rom_ptr    = ptr_q;
	assign busy       = (state != pr_idle);
	assign print_done = done_q;
	assign char_valid = valid_q;
	assign char_data  = char_q;

endmodule

// ==== source/test_sequencer.sv ====
/*
 * Main controller of the self-test. Waits for a button, prints the
 * title, waits for DRAM init, then writes an incrementing pattern and
 * reads it back, reporting every mismatch. Phase shown on the LEDs.
 */
`timescale 1ns/1ps

module test_sequencer
	import memtest_pkg::*;
(
	input  logic       clk,
	input  logic       reset_n,
	input  logic [4:0] button,
	output led_t       led,
	input  logic       sdram_init_busy,
	output logic       dram_valid,
	input  logic       dram_ready,
	output dram_req_t  dram_req,
	input  dram_data_t dram_rdata,
	input  logic       dram_rdata_valid,
	output logic       print_start,
	output print_req_t print_req,
	input  logic       print_done
);

	seq_state_t state;
	led_t       led_q;
	logic       dram_valid_q;
	logic       start_q;
	// High in the write pass, low in the read pass
	logic       write_q;
	burst_t     burst_q;
	msg_id_t    msg_q;
	// Last mismatching read data
	dram_data_t err_data_q;

	dram_addr_t burst_addr;
	dram_data_t pattern;
	logic       last_burst;
	logic       progress_due;

	// Address and expected data follow the burst index
	assign burst_addr   = dram_addr_t'(burst_q) * addr_step;
	assign pattern      = dram_data_t'(burst_q);
	assign last_burst   = (burst_q == burst_t'(test_word_count - 1));
	assign progress_due = ((burst_q % burst_t'(progress_words)) == '0);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state        <= seq_wait_button;
			led_q        <= led_idle;
			dram_valid_q <= 1'b0;
			start_q      <= 1'b0;
			write_q      <= 1'b1;
			burst_q      <= '0;
		end else begin
			// Print start is a single-cycle pulse
			start_q <= 1'b0;
			case (state)
				// ----------------------------------------
				// Startup
				// ----------------------------------------
				seq_wait_button: begin
					// Any button pulls its line low
					if (button != 5'b11111) begin
						msg_q   <= msg_title;
						start_q <= 1'b1;
						state   <= seq_title_wait;
					end
				end
				seq_title_wait: begin
					if (print_done) begin
						led_q <= led_wait_init;
						state <= seq_wait_init;
					end
				end
				seq_wait_init: begin
					if (!sdram_init_busy) begin
						led_q   <= led_write;
						msg_q   <= msg_init_ok;
						start_q <= 1'b1;
						state   <= seq_init_ok_wait;
					end
				end
				seq_init_ok_wait: begin
					if (print_done) begin
						write_q <= 1'b1;
						burst_q <= '0;
						state   <= seq_burst;
					end
				end
				// ----------------------------------------
				// Burst loop, shared by both passes
				// ----------------------------------------
				seq_burst: begin
					if (progress_due) begin
						msg_q   <= write_q ? msg_write : msg_read;
						start_q <= 1'b1;
						state   <= seq_progress_wait;
					end else begin
						dram_valid_q <= 1'b1;
						state        <= seq_request;
					end
				end
				seq_progress_wait: begin
					// Request only after the progress line is out
					if (print_done) begin
						dram_valid_q <= 1'b1;
						state        <= seq_request;
					end
				end
				seq_request: begin
					if (dram_ready) begin
						dram_valid_q <= 1'b0;
						if (!write_q) begin
							state <= seq_read_data;
						end else if (last_burst) begin
							// Write pass over, restart for reading
							write_q <= 1'b0;
							burst_q <= '0;
							led_q   <= led_read;
							state   <= seq_burst;
						end else begin
							burst_q <= burst_q + 1'b1;
							state   <= seq_burst;
						end
					end
				end
				// ----------------------------------------
				// Compare and report
				// ----------------------------------------
				seq_read_data: begin
					if (dram_rdata_valid) begin
						if (dram_rdata != pattern) begin
							err_data_q <= dram_rdata;
							msg_q      <= msg_read_error;
							start_q    <= 1'b1;
							state      <= seq_error_wait;
						end else if (last_burst) begin
							led_q <= led_done;
							state <= seq_done;
						end else begin
							burst_q <= burst_q + 1'b1;
							state   <= seq_burst;
						end
					end
				end
				seq_error_wait: begin
					// Carry on with the next burst
					if (print_done) begin
						if (last_burst) begin
							led_q <= led_done;
							state <= seq_done;
						end else begin
							burst_q <= burst_q + 1'b1;
							state   <= seq_burst;
						end
					end
				end
				seq_done: state <= seq_done;
				default: state <= seq_wait_button;
			endcase
		end
	end

	assign led         = led_q;
	assign dram_valid  = dram_valid_q;
	assign dram_req    = '{addr: burst_addr, write: write_q, wdata: pattern};
	assign print_start = start_q;
	assign print_req   = '{msg: msg_q, addr: hex_addr_t'(burst_addr), data: err_data_q};

endmodule

// ==== source/memtest_top.sv ====
/*
 * Top level of the DDR3 self-test controller.
 * Joins the sequencer, the print engine and the message ROM.
 */
`timescale 1ns/1ps

module memtest_top
	import memtest_pkg::*;
(
	input  logic       clk,
	input  logic       reset_n,
	input  logic [4:0] button,
	output led_t       led,
	// High while the memory controller initializes
	input  logic       sdram_init_busy,
	// Character stream
	output logic       char_valid,
	input  logic       char_ready,
	output char_t      char_data,
	// DRAM request and read return
	output logic       dram_valid,
	input  logic       dram_ready,
	output dram_req_t  dram_req,
	input  dram_data_t dram_rdata,
	input  logic       dram_rdata_valid
);

	// ----------------------------------------
	// Internal links
	// ----------------------------------------
	logic       print_start;
	print_req_t print_req;
	logic       print_done;
	rom_ptr_t   rom_ptr;
	char_t      rom_char;

	test_sequencer u_sequencer (
		.clk              (clk),
		.reset_n          (reset_n),
		.button           (button),
		.led              (led),
		.sdram_init_busy  (sdram_init_busy),
		.dram_valid       (dram_valid),
		.dram_ready       (dram_ready),
		.dram_req         (dram_req),
		.dram_rdata       (dram_rdata),
		.dram_rdata_valid (dram_rdata_valid),
		.print_start      (print_start),
		.print_req        (print_req),
		.print_done       (print_done)
	);

	message_printer u_printer (
		.clk         (clk),
		.reset_n     (reset_n),
		.print_start (print_start),
		.print_req   (print_req),
		.rom_ptr     (rom_ptr),
		.rom_char    (rom_char),
		.busy        (),
		.print_done  (print_done),
		.char_valid  (char_valid),
		.char_ready  (char_ready),
		.char_data   (char_data)
	);

	message_rom u_rom (
		.rom_ptr  (rom_ptr),
		.rom_char (rom_char)
	);

endmodule

// ==== bench/dram_model.sv ====
/*
 * Behavioral DRAM for the self-test testbench. Stalls ready at random,
 * answers reads after 1 to 4 cycles and flips bit 0 of one burst.
 */
`timescale 1ns/1ps

module dram_model
	import memtest_pkg::*;
(
	input  logic       clk,
	input  logic       reset_n,
	input  int         fault_burst,
	input  logic       dram_valid,
	output logic       dram_ready = 1'b0,
	input  dram_req_t  dram_req,
	output dram_data_t dram_rdata = '0,
	output logic       dram_rdata_valid = 1'b0
);

	dram_data_t mem [test_word_count];
	// Handshake seen at the last rising edge
	logic       accepted = 1'b0;
	dram_req_t  acc_req;
	logic       pending = 1'b0;
	int         delay;
	int         index;

	always @(posedge clk) begin
		accepted <= reset_n && dram_valid && dram_ready;
		acc_req  <= dram_req;
	end

	// Outputs change on the falling edge only
	always @(negedge clk) begin
		if (!reset_n) begin
			dram_ready       <= 1'b0;
			dram_rdata_valid <= 1'b0;
			pending          = 1'b0;
		end else begin
			dram_ready       <= ($urandom % 3) != 0;
			dram_rdata_valid <= 1'b0;
			if (accepted) begin
				index = int'(acc_req.addr / 8) % test_word_count;
				if (acc_req.write) begin
					mem[index] = acc_req.wdata;
				end else begin
					pending = 1'b1;
					delay   = 1 + ($urandom % 4);
				end
			end else if (pending) begin
				delay = delay - 1;
				if (delay == 0) begin
					// Faulty word reads back with bit 0 inverted
					dram_rdata       <= mem[index] ^ dram_data_t'(index == fault_burst);
					dram_rdata_valid <= 1'b1;
					pending          = 1'b0;
				end
			end
		end
	end

endmodule

// ==== bench/memtest_tb.sv ====
/*
 * Testbench of the DDR3 self-test controller. Builds the expected text
 * and request order, presses a button, releases DRAM init, and checks
 * both streams under random back-pressure against a DRAM model.
 */
`timescale 1ns/1ps

module memtest_tb
	import memtest_pkg::*;
();

	localparam int half_period = 20;
	localparam int fault_burst = 37;
	localparam int idle_cycles = 30;
	localparam int init_hold_cycles = 25;
	// Cycle envelope per character and per request under stalls
	localparam int char_cycles_max = 16;
	localparam int dram_cycles_max = 24;

	logic       clk;
	logic       reset_n;
	logic [4:0] button;
	led_t       led;
	logic       sdram_init_busy;
	logic       char_valid;
	logic       char_ready;
	char_t      char_data;
	logic       dram_valid;
	logic       dram_ready;
	dram_req_t  dram_req;
	dram_data_t dram_rdata;
	logic       dram_rdata_valid;

	// Expected streams and the character count at each request
	char_t      exp_chars[$];
	dram_req_t  exp_reqs[$];
	int         exp_marks[$];
	int         title_len;
	int         init_len;
	int         chars_seen;
	int         reqs_seen;
	int         watchdog_cycles;
	logic       char_hold;
	char_t      char_prev;
	logic       req_hold;
	dram_req_t  req_prev;
	dram_req_t  want;

	memtest_top dut (
		.clk              (clk),
		.reset_n          (reset_n),
		.button           (button),
		.led              (led),
		.sdram_init_busy  (sdram_init_busy),
		.char_valid       (char_valid),
		.char_ready       (char_ready),
		.char_data        (char_data),
		.dram_valid       (dram_valid),
		.dram_ready       (dram_ready),
		.dram_req         (dram_req),
		.dram_rdata       (dram_rdata),
		.dram_rdata_valid (dram_rdata_valid)
	);

	dram_model u_dram (
		.clk              (clk),
		.reset_n          (reset_n),
		.fault_burst      (fault_burst),
		.dram_valid       (dram_valid),
		.dram_ready       (dram_ready),
		.dram_req         (dram_req),
		.dram_rdata       (dram_rdata),
		.dram_rdata_valid (dram_rdata_valid)
	);

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	// ----------------------------------------
	// Failure reporting
	// ----------------------------------------
	task automatic fail_with(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic value_error(input string name, input logic [$bits(dram_req_t)-1:0] got,
			input logic [$bits(dram_req_t)-1:0] exp);
		fail_with($sformatf("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp,
			$time));
	endtask

	// ----------------------------------------
	// Expected stream builder
	// ----------------------------------------
	task automatic add_text(input string s);
		for (int i = 0; i < s.len(); i++) begin
			exp_chars.push_back(char_t'(s[i]));
		end
	endtask

	task automatic add_eol();
		exp_chars.push_back(8'h0D);
		exp_chars.push_back(8'h0A);
	endtask

	// Most significant digit first in upper case
	task automatic add_hex(input logic [127:0] value, input int digits);
		logic [3:0] nib;
		for (int i = digits - 1; i >= 0; i--) begin
			nib = value[4*i +: 4];
			if (nib < 4'd10) begin
				exp_chars.push_back("0" + char_t'(nib));
			end else begin
				exp_chars.push_back("A" + char_t'(nib - 4'd10));
			end
		end
	endtask

	task automatic add_pass(input logic write);
		dram_req_t r;
		for (int k = 0; k < test_word_count; k++) begin
			if (k % progress_words == 0) begin
				add_text(write ? "W:" : "R:");
				add_hex(128'(k * 8), addr_hex_digits);
				add_eol();
			end
			r.addr  = dram_addr_t'(k * 8);
			r.write = write;
			r.wdata = dram_data_t'(k);
			exp_reqs.push_back(r);
			exp_marks.push_back(exp_chars.size());
			// Mismatch line follows the read of the faulty burst
			if (!write && k == fault_burst) begin
				add_text(" Read Err ");
				add_hex(128'(k * 8), addr_hex_digits);
				add_text(":");
				add_hex(128'(k ^ 1), data_hex_digits);
				add_eol();
			end
		end
	endtask

	task automatic build_expected();
		add_text("DDR3 Test");
		add_eol();
		add_text("Wait init");
		add_eol();
		title_len = exp_chars.size();
		add_text("Init OK");
		add_eol();
		add_text("Write");
		add_eol();
		init_len = exp_chars.size();
		add_pass(1'b1);
		add_pass(1'b0);
	endtask

	// ----------------------------------------
	// Stream monitor sampled on the rising edge
	// ----------------------------------------
	always @(posedge clk) begin
		if (reset_n) begin
			if (char_hold) begin
				assert (char_valid) else fail_with("char_valid dropped before acceptance");
				assert (char_data == char_prev) else value_error("char_data", char_data, char_prev);
			end
			if (req_hold) begin
				assert (dram_valid) else fail_with("dram_valid dropped before acceptance");
				assert (dram_req == req_prev) else value_error("dram_req", dram_req, req_prev);
			end
			if (dram_valid && dram_ready) begin
				assert (reqs_seen < exp_reqs.size()) else fail_with("Unexpected extra DRAM request");
				want = exp_reqs[reqs_seen];
				assert (dram_req.addr == want.addr)
					else value_error("dram_req.addr", dram_req.addr, want.addr);
				assert (dram_req.write == want.write)
					else value_error("dram_req.write", dram_req.write, want.write);
				if (want.write) begin
					assert (dram_req.wdata == want.wdata)
						else value_error("dram_req.wdata", dram_req.wdata, want.wdata);
				end
				assert (led == (want.write ? led_write : led_read))
					else value_error("led", led, want.write ? led_write : led_read);
				// Progress line must be complete before its request
				assert (chars_seen == exp_marks[reqs_seen])
					else fail_with($sformatf("Request %0d came after %0d characters, expected %0d",
						reqs_seen, chars_seen, exp_marks[reqs_seen]));
				reqs_seen = reqs_seen + 1;
			end
			if (char_valid && char_ready) begin
				assert (chars_seen < exp_chars.size()) else fail_with("Unexpected extra character");
				assert (char_data == exp_chars[chars_seen])
					else value_error("char_data", char_data, exp_chars[chars_seen]);
				chars_seen = chars_seen + 1;
			end
			char_hold = char_valid && !char_ready;
			char_prev = char_data;
			req_hold  = dram_valid && !dram_ready;
			req_prev  = dram_req;
		end
	end

	// Random character back-pressure
	always @(negedge clk) begin
		if (reset_n) begin
			char_ready = ($urandom % 4) != 0;
		end
	end

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		void'($urandom(91146));
		reset_n         = 1'b0;
		button          = 5'b11111;
		sdram_init_busy = 1'b1;
		char_ready      = 1'b0;
		chars_seen      = 0;
		reqs_seen       = 0;
		char_hold       = 1'b0;
		req_hold        = 1'b0;
		build_expected();
		watchdog_cycles = exp_chars.size() * char_cycles_max
			+ exp_reqs.size() * dram_cycles_max + idle_cycles + init_hold_cycles + 200;
		fork
			begin
				repeat (watchdog_cycles) @(posedge clk);
				fail_with("Watchdog expired before the test sequence finished");
			end
		join_none
		repeat (4) @(negedge clk);
		reset_n = 1'b1;

		// Buttons released and no activity allowed
		repeat (idle_cycles) begin
			@(negedge clk);
			assert (led == led_idle) else value_error("led", led, led_idle);
			assert (!char_valid) else fail_with("Character sent before a button press");
			assert (!dram_valid) else fail_with("DRAM request before a button press");
		end

		// One button pulled low
		button = 5'b11011;
		repeat (2) @(negedge clk);
		button = 5'b11111;
		while (chars_seen < title_len) @(negedge clk);
		while (led == led_idle) @(negedge clk);
		repeat (init_hold_cycles) begin
			assert (led == led_wait_init) else value_error("led", led, led_wait_init);
			assert (!dram_valid) else fail_with("DRAM request during memory init");
			assert (!char_valid) else fail_with("Character sent during memory init");
			@(negedge clk);
		end
		sdram_init_busy = 1'b0;
		while (chars_seen < init_len) @(negedge clk);
		assert (led == led_write) else value_error("led", led, led_write);

		// Both passes and a quiet tail for stray output
		while (reqs_seen < exp_reqs.size() || chars_seen < exp_chars.size() || led == led_read)
			@(negedge clk);
		repeat (10) @(negedge clk);
		assert (led == led_done) else value_error("led", led, led_done);
		$display("Test completed successfully");
		$finish;
	end

endmodule

// ==== memtest.f ====
source/memtest_pkg.sv
source/message_rom.sv
source/message_printer.sv
source/test_sequencer.sv
source/memtest_top.sv
bench/dram_model.sv
bench/memtest_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the self-test testbench with Verilator and run it.
# Exit status is 0 only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module memtest_tb -f memtest.f -o memtest_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/memtest_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
fi

if grep -q "Test completed successfully" sim.log; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1
